// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Datapath widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // RAM geometry, index wraps modulo the depth
    localparam int MEM_DEPTH_WORDS = 1024;
    localparam int WORD_IDX_W      = $clog2(MEM_DEPTH_WORDS);

    // Cycles from read enable to valid read data
    localparam int MEM_READ_LATENCY = 2;
    localparam int LAT_CNT_W        = $clog2(MEM_READ_LATENCY + 1);

    // RV32 func3 codes for loads and stores
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_NOP
    } mem_op_t;

    typedef struct packed {
        logic              is_store;
        logic [2:0]        func3;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage : mem_pkg

`default_nettype wire

// ==== mem_controller/lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_align (
    input  wire mem_pkg::mem_op_t               op,
    input  wire logic [1:0]                     offset,
    input  wire logic [mem_pkg::DATA_W-1:0]     word,
    input  wire logic [mem_pkg::DATA_W-1:0]     store_data,
    output logic [mem_pkg::DATA_W-1:0]          load_word,
    output logic [mem_pkg::DATA_W-1:0]          merged_word
);
    import mem_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [4:0]  byte_lsb;
    logic [4:0]  half_lsb;

    // Bit positions of the addressed lanes
    assign byte_lsb = {offset, 3'b000};
    assign half_lsb = {offset[1], 4'b0000};

    assign sel_byte = word[byte_lsb +: 8];
    assign sel_half = word[half_lsb +: 16];

    // Load extraction with sign or zero fill
    always_comb begin
        case (op)
            OP_LB:   load_word = {{(DATA_W-8){sel_byte[7]}}, sel_byte};
            OP_LBU:  load_word = {{(DATA_W-8){1'b0}}, sel_byte};
            OP_LH:   load_word = {{(DATA_W-16){sel_half[15]}}, sel_half};
            OP_LHU:  load_word = {{(DATA_W-16){1'b0}}, sel_half};
            OP_LW:   load_word = word;
            default: load_word = '0;
        endcase
    end

    // Store merge keeps the untouched lanes of the old word
    always_comb begin
        merged_word = word;
        case (op)
            OP_SB:   merged_word[byte_lsb +: 8]  = store_data[7:0];
            OP_SH:   merged_word[half_lsb +: 16] = store_data[15:0];
            default: merged_word = word;
        endcase
    end

endmodule : lane_align

`default_nettype wire

// ==== mem_controller/mem_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_controller (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire logic                             req,
    input  wire mem_pkg::mem_req_t                req_data,
    output logic                                  ack,
    output logic [mem_pkg::DATA_W-1:0]            rdata,
    output mem_pkg::mem_op_t                      op,
    output logic [1:0]                            offset,
    output logic [mem_pkg::DATA_W-1:0]            store_data,
    input  wire logic [mem_pkg::DATA_W-1:0]       load_word,
    input  wire logic [mem_pkg::DATA_W-1:0]       merged_word,
    output logic                                  ram_rd,
    output logic                                  ram_wr,
    output logic [mem_pkg::WORD_IDX_W-1:0]        ram_idx,
    output logic [mem_pkg::DATA_W-1:0]            ram_wdata,
    input  wire logic [mem_pkg::DATA_W-1:0]       ram_rdata
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ_WAIT,
        WRITE,
        RESPOND,
        RELEASE
    } state_t;

    state_t                state;
    logic [LAT_CNT_W-1:0]  wait_cnt;
    logic                  read_done;
    logic [DATA_W-1:0]     merge_q;
    mem_op_t               req_op;

    // Map the raw func3 onto an access kind, illegal codes become NOP
    function automatic mem_op_t decode_op(input logic is_store, input logic [2:0] f3);
        mem_op_t kind;
        kind = OP_NOP;
        if (is_store) begin
            case (f3)
                F3_B:    kind = OP_SB;
                F3_H:    kind = OP_SH;
                F3_W:    kind = OP_SW;
                default: kind = OP_NOP;
            endcase
        end else begin
            case (f3)
                F3_B:    kind = OP_LB;
                F3_H:    kind = OP_LH;
                F3_W:    kind = OP_LW;
                F3_BU:   kind = OP_LBU;
                F3_HU:   kind = OP_LHU;
                default: kind = OP_NOP;
            endcase
        end
        return kind;
    endfunction

    assign req_op    = decode_op(req_data.is_store, req_data.func3);
    assign read_done = (state == READ_WAIT) && (wait_cnt == LAT_CNT_W'(MEM_READ_LATENCY));

    // Read strobe only in the first wait cycle
    assign ram_rd    = (state == READ_WAIT) && (wait_cnt == '0);
    assign ram_wr    = (state == WRITE);
    assign ram_wdata = (op == OP_SW) ? store_data : merge_q;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= IDLE;
            wait_cnt <= '0;
            ack      <= 1'b0;
            rdata    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        rdata    <= '0;
                        wait_cnt <= '0;
                        case (req_op)
                            OP_NOP:  state <= RESPOND;
                            OP_SW:   state <= WRITE;
                            default: state <= READ_WAIT;
                        endcase
                    end
                end
                READ_WAIT: begin
                    if (read_done) begin
                        // Partial stores go on to the merged write
                        if (op == OP_SB || op == OP_SH) begin
                            state <= WRITE;
                        end else begin
                            rdata <= load_word;
                            state <= RESPOND;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                WRITE: begin
                    state <= RESPOND;
                end
                RESPOND: begin
                    ack   <= 1'b1;
                    state <= RELEASE;
                end
                RELEASE: begin
                    // Hold ack until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request payload, captured once per transaction
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            op         <= req_op;
            ram_idx    <= req_data.addr[WORD_IDX_W+1:2];
            offset     <= req_data.addr[1:0];
            store_data <= req_data.wdata;
        end
        if (read_done) begin
            merge_q <= merged_word;
        end
    end

endmodule : mem_controller

`default_nettype wire

// ==== design/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int DEPTH = mem_pkg::MEM_DEPTH_WORDS
) (
    input  wire logic                           clk,
    input  wire logic                           rd,
    input  wire logic                           wr,
    input  wire logic [$clog2(DEPTH)-1:0]       idx,
    input  wire logic [mem_pkg::DATA_W-1:0]     wdata,
    output logic [mem_pkg::DATA_W-1:0]          rdata
);
    import mem_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rd_stage;

    // Write wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[idx] <= wdata;
        end else if (rd) begin
            rd_stage <= mem[idx];
        end
    end

    // Second read stage
    always_ff @(posedge clk) begin
        rdata <= rd_stage;
    end

endmodule : data_ram

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       req,
    input  wire mem_pkg::mem_req_t          req_data,
    output logic                            ack,
    output logic [mem_pkg::DATA_W-1:0]      rdata
);
    import mem_pkg::*;

    mem_op_t                op;
    logic [1:0]             offset;
    logic [DATA_W-1:0]      store_data;
    logic [DATA_W-1:0]      load_word;
    logic [DATA_W-1:0]      merged_word;
    logic                   ram_rd;
    logic                   ram_wr;
    logic [WORD_IDX_W-1:0]  ram_idx;
    logic [DATA_W-1:0]      ram_wdata;
    logic [DATA_W-1:0]      ram_rdata;

    mem_controller u_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .req_data    (req_data),
        .ack         (ack),
        .rdata       (rdata),
        .op          (op),
        .offset      (offset),
        .store_data  (store_data),
        .load_word   (load_word),
        .merged_word (merged_word),
        .ram_rd      (ram_rd),
        .ram_wr      (ram_wr),
        .ram_idx     (ram_idx),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    // Lane logic works on the live RAM output
    lane_align u_lane (
        .op          (op),
        .offset      (offset),
        .word        (ram_rdata),
        .store_data  (store_data),
        .load_word   (load_word),
        .merged_word (merged_word)
    );

    data_ram #(
        .DEPTH (MEM_DEPTH_WORDS)
    ) u_ram (
        .clk   (clk),
        .rd    (ram_rd),
        .wr    (ram_wr),
        .idx   (ram_idx),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule : mem_subsystem

`default_nettype wire

// ==== bench/mem_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sva (
    input wire logic clk,
    input wire logic rstN,
    input wire logic req,
    input wire logic ack,
    input wire logic ram_rd,
    input wire logic ram_wr
);

    // ack only rises under a pending request
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    ack_held_until_release: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    // RAM strobes only while a request waits for its ack
    ram_access_in_txn: assert property (@(posedge clk) disable iff (!rstN)
        (ram_rd || ram_wr) |-> req && !ack)
        else $error("RAM accessed outside an open request");

    ack_low_after_reset: assert property (@(posedge clk) !rstN |=> !ack)
        else $error("ack not low after reset");

endmodule : mem_sva

bind mem_controller mem_sva u_sva (
    .clk(clk), .rstN(rstN), .req(req), .ack(ack), .ram_rd(ram_rd), .ram_wr(ram_wr)
);

`default_nettype wire

// ==== bench/mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_tb;
    import mem_pkg::*;

    // Fill and read back, random loads, store pairs, illegal codes, wrap pairs
    localparam int NUM_TXN = 128 + 300 + 2 * 100 + 13 + 2 * 16;

    logic        clk;
    logic        rstN;
    logic        req;
    mem_req_t    req_data;
    logic        ack;
    logic [31:0] rdata;
    logic [31:0] lfsr_state = 32'h8795;
    logic [31:0] model_mem [64];

    mem_subsystem u_mem_subsystem (
        .clk(clk), .rstN(rstN), .req(req), .req_data(req_data), .ack(ack), .rdata(rdata)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Random high bits exercise the wrap, bits 11:8 stay zero to hit the window
    function automatic logic [31:0] rand_addr();
        logic [31:0] high;
        logic [31:0] low;
        high = rand_bits(20);
        low  = rand_bits(8);
        return {high[19:0], 4'b0000, low[7:0]};
    endfunction

    function automatic logic [5:0] model_index(input logic [31:0] addr);
        logic [31:0] word_idx;
        word_idx = (addr >> 2) % 32'(MEM_DEPTH_WORDS);
        return word_idx[5:0];
    endfunction

    function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[model_index(addr)];
        b = 8'(w >> {addr[1:0], 3'b000});
        h = 16'(w >> {addr[1], 4'b0000});
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_W:    return w;
            F3_BU:   return {24'h0, b};
            F3_HU:   return {16'h0, h};
            default: return 32'h0;
        endcase
    endfunction

    function automatic void apply_store(input logic [2:0] f3, input logic [31:0] addr,
                                        input logic [31:0] data);
        logic [31:0] mask;
        logic [4:0]  sh;
        logic [5:0]  idx;
        idx = model_index(addr);
        sh  = (f3 == F3_H) ? {addr[1], 4'b0000} : {addr[1:0], 3'b000};
        case (f3)
            F3_B:    mask = 32'h0000_00FF << sh;
            F3_H:    mask = 32'h0000_FFFF << sh;
            F3_W:    mask = 32'hFFFF_FFFF;
            default: mask = 32'h0;
        endcase
        if (f3 == F3_W) sh = 5'd0;
        model_mem[idx] = (model_mem[idx] & ~mask) | ((data << sh) & mask);
    endfunction

    // Cycles from the sampling edge to ack
    function automatic int access_latency(input logic is_store, input logic [2:0] f3);
        if (is_store) begin
            return (f3 == F3_B || f3 == F3_H) ? MEM_READ_LATENCY + 3 : (f3 == F3_W) ? 2 : 1;
        end
        return (f3 == 3'd3 || f3 > 3'd5) ? 1 : MEM_READ_LATENCY + 2;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error %s actual=%h expected=%h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_stall(input string what);
        $display("Timeout: %s", what);
        $display("Test failed");
        $fatal(1, "handshake stalled");
    endtask

    // One four-phase transaction, hold keeps req high for extra cycles after ack
    task automatic run_access(input logic is_store, input logic [2:0] f3,
                              input logic [31:0] addr, input logic [31:0] wdata, input int hold);
        logic [31:0] expected;
        int          cycles;
        expected = is_store ? 32'h0 : expected_load(f3, addr);
        @(posedge clk);
        req      <= 1'b1;
        req_data <= '{is_store: is_store, func3: f3, addr: addr, wdata: wdata};
        cycles = 0;
        @(negedge clk);
        while (!ack) begin
            cycles++;
            if (cycles > 20) report_stall("ack did not rise within 20 cycles");
            @(negedge clk);
        end
        check_value("ack_latency", 32'(cycles - 1), 32'(access_latency(is_store, f3)));
        check_value("rdata", rdata, expected);
        repeat (hold) begin
            @(negedge clk);
            check_value("ack", 32'(ack), 32'h1);
            check_value("rdata", rdata, expected);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_value("ack", 32'(ack), 32'h1);
        cycles = 0;
        while (ack) begin
            cycles++;
            if (cycles > 20) report_stall("ack did not fall after req was released");
            @(negedge clk);
        end
        if (is_store) apply_store(f3, addr, wdata);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        int          hold;
        clk      = 1'b0;
        rstN     = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            data = rand_bits(32);
            run_access(1'b1, F3_W, 32'(i) << 2, data, 0);
        end
        for (int i = 0; i < 64; i++) run_access(1'b0, F3_W, 32'(i) << 2, 32'h0, 0);
        // Random legal loads with back-pressure
        for (int i = 0; i < 300; i++) begin
            do begin
                r = rand_bits(3);
            end while (r == 3 || r == 6 || r == 7);
            addr = rand_addr();
            hold = int'(rand_bits(3));
            run_access(1'b0, r[2:0], addr, 32'h0, hold);
        end
        for (int i = 0; i < 100; i++) begin
            r    = rand_bits(1);
            addr = rand_addr();
            data = rand_bits(32);
            hold = int'(rand_bits(3));
            run_access(1'b1, {2'b00, r[0]}, addr, data, hold);
            run_access(1'b0, F3_W, addr, 32'h0, 0);
        end
        // Illegal codes complete as NOP
        for (int f = 3; f < 8; f++) begin
            addr = rand_addr();
            data = rand_bits(32);
            if (f == 3 || f >= 6) run_access(1'b0, 3'(f), addr, 32'h0, 0);
            run_access(1'b1, 3'(f), addr, data, 0);
            run_access(1'b0, F3_W, addr, 32'h0, 0);
        end
        for (int i = 0; i < 16; i++) begin
            r    = rand_bits(6);
            data = rand_bits(32);
            run_access(1'b1, F3_W, (32'(r[5:0]) + 32'(MEM_DEPTH_WORDS)) << 2, data, 0);
            run_access(1'b0, F3_W, 32'(r[5:0]) << 2, 32'h0, 0);
        end
        $display("Test passed");
        $finish;
    end

    initial begin
        #(NUM_TXN * 20 * 4 + 500);
        $display("Watchdog expired before all transactions completed");
        $display("Test failed");
        $fatal(1, "simulation time limit reached");
    end

endmodule : mem_tb

`default_nettype wire

// ==== build.f ====
common/mem_pkg.sv
mem_controller/lane_align.sv
mem_controller/mem_controller.sv
design/data_ram.sv
design/mem_subsystem.sv
bench/mem_sva.sv
bench/mem_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' build.f)

obj_dir/Vmem_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module mem_tb -f build.f -o Vmem_tb

run: obj_dir/Vmem_tb
	./obj_dir/Vmem_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
